//--- rtl/sensor_pkg.sv
//~~~~~~~~~~~~~~~~~~
// one sensor channel, all logic on mclk
// addresses are absolute 16-bit command bus addresses
//~~~~~~~~~~~~~~~~~~
package sensor_pkg;

    // widths
    localparam int unsigned PXD_W       = 12;   // sensor pixel
    localparam int unsigned DOUT_W      = 16;   // packed output word
    localparam int unsigned CMD_DATA_W  = 32;   // command payload
    localparam int unsigned CMD_ADDR_W  = 16;   // command address
    localparam int unsigned SYNC_MULT_W = 8;    // frame decimation count

    // command bus framing: AL, AH, D0..D3
    localparam int unsigned CMD_NUM_BYTES = 6;

    // address map
    localparam logic [CMD_ADDR_W-1:0] SENSOR_BASE_ADDR           = 16'h0400;
    localparam logic [CMD_ADDR_W-1:0] SENSOR_CTRL_RADDR          = 16'h0000; // mode
    localparam logic [CMD_ADDR_W-1:0] SENS_SYNC_MULT_RADDR       = 16'h0006; // frame multiple
    localparam logic [CMD_ADDR_W-1:0] SENS_GAMMA_ADDR_DATA_RADDR = 16'h0039; // pointer/data port

    // mode register fields
    localparam int unsigned SENSOR_16BIT_BIT = 8;     // 1 = 16-bit bypass, 0 = 8-bit gamma

    // gamma table
    localparam int unsigned GAMMA_ADDR_FLAG_BIT = 20; // set: word is a table pointer
    localparam int unsigned GAMMA_ENTRIES       = 64;
    localparam int unsigned GAMMA_IDX_W         = 6;
    localparam int unsigned GAMMA_OUT_W         = 8;

    typedef enum logic [2:0] {
        CMD_IDLE,      // waiting for strobe
        CMD_ADDR_HI,   // address high byte on bus
        CMD_DATA0,
        CMD_DATA1,
        CMD_DATA2,
        CMD_DATA3      // last byte, write happens here
    } cmd_state_e;

    typedef enum logic [1:0] {
        SEL_NONE,        // not this channel
        SEL_MODE,
        SEL_SYNC_MULT,
        SEL_GAMMA_PORT
    } reg_sel_e;

    typedef struct packed {
        logic [PXD_W-1:0] pxd;   // raw pixel
        logic             hact;  // line active
        logic             sof;   // start of frame pulse
        logic             eof;   // end of frame pulse
    } pix_in_t;

    typedef struct packed {
        logic [GAMMA_OUT_W-1:0] pxd;   // gamma result
        logic                   hact;
        logic                   sof;
        logic                   eof;
    } pix8_t;

    typedef struct packed {
        logic                   we;     // one-cycle write strobe
        logic [GAMMA_IDX_W-1:0] idx;    // table entry
        logic [GAMMA_OUT_W-1:0] value;  // entry data
    } gamma_wr_t;

endpackage

//--- rtl/sensor_cmd_regs.sv
//~~~~~~~~~~~~~~~~~~
// expects registered cmd bus, strobe with address low byte
// write lands on the d3 byte; a new strobe aborts the command
//~~~~~~~~~~~~~~~~~~
module sensor_cmd_regs (
    input  logic                                  mclk,
    input  logic                                  rst,
    input  logic [7:0]                            cmd_ad_i,    // byte-serial addr/data
    input  logic                                  cmd_stb_i,   // with address low byte
    output logic                                  bit16_o,     // 16-bit bypass mode
    output logic [sensor_pkg::SYNC_MULT_W-1:0]    sync_mult_o, // keep 1 of mult+1 frames
    output sensor_pkg::gamma_wr_t                 gamma_wr_o   // table write port
);

    sensor_pkg::cmd_state_e                       state;
    sensor_pkg::reg_sel_e                         reg_sel;
    logic [sensor_pkg::CMD_ADDR_W-1:0]            addr_r;     // full command address
    logic [(sensor_pkg::CMD_NUM_BYTES-3)*8-1:0]   data_lo;    // d0..d2
    logic [sensor_pkg::CMD_DATA_W-1:0]            data_w;     // complete payload on d3 cycle
    logic                                         wr_en;
    logic [sensor_pkg::GAMMA_IDX_W-1:0]           gamma_ptr;  // auto-incrementing pointer
    logic                                         gamma_we;
    logic [sensor_pkg::GAMMA_IDX_W-1:0]           gamma_idx;
    logic [sensor_pkg::GAMMA_OUT_W-1:0]           gamma_val;

    assign data_w = {cmd_ad_i, data_lo};                      // d3 straight from the bus
    assign wr_en  = (state == sensor_pkg::CMD_DATA3) && !cmd_stb_i;

    // byte sequencer
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state <= sensor_pkg::CMD_IDLE;
        end else if (cmd_stb_i) begin
            state <= sensor_pkg::CMD_ADDR_HI;                 // (re)start on any strobe
        end else begin
            case (state)
                sensor_pkg::CMD_ADDR_HI: state <= sensor_pkg::CMD_DATA0;
                sensor_pkg::CMD_DATA0:   state <= sensor_pkg::CMD_DATA1;
                sensor_pkg::CMD_DATA1:   state <= sensor_pkg::CMD_DATA2;
                sensor_pkg::CMD_DATA2:   state <= sensor_pkg::CMD_DATA3;
                default:                 state <= sensor_pkg::CMD_IDLE;
            endcase
        end
    end

    // address and data bytes
    always_ff @(posedge mclk) begin
        if (cmd_stb_i) begin
            addr_r[7:0] <= cmd_ad_i;                          // address low
        end else begin
            case (state)
                sensor_pkg::CMD_ADDR_HI: addr_r[sensor_pkg::CMD_ADDR_W-1:8] <= cmd_ad_i;
                sensor_pkg::CMD_DATA0:   data_lo[7:0]   <= cmd_ad_i;
                sensor_pkg::CMD_DATA1:   data_lo[15:8]  <= cmd_ad_i;
                sensor_pkg::CMD_DATA2:   data_lo[23:16] <= cmd_ad_i;
                default: ;
            endcase
        end
    end

    // full address decode, other channels fall to none
    always_comb begin
        reg_sel = sensor_pkg::SEL_NONE;
        if (addr_r == sensor_pkg::SENSOR_BASE_ADDR + sensor_pkg::SENSOR_CTRL_RADDR)
            reg_sel = sensor_pkg::SEL_MODE;
        else if (addr_r == sensor_pkg::SENSOR_BASE_ADDR + sensor_pkg::SENS_SYNC_MULT_RADDR)
            reg_sel = sensor_pkg::SEL_SYNC_MULT;
        else if (addr_r == sensor_pkg::SENSOR_BASE_ADDR + sensor_pkg::SENS_GAMMA_ADDR_DATA_RADDR)
            reg_sel = sensor_pkg::SEL_GAMMA_PORT;
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            bit16_o     <= 1'b0;                              // 8-bit gamma mode
            sync_mult_o <= '0;                                // every frame
            gamma_ptr   <= '0;
            gamma_we    <= 1'b0;
        end else begin
            gamma_we <= 1'b0;                                 // single-cycle pulse
            if (wr_en) begin
                case (reg_sel)
                    sensor_pkg::SEL_MODE:
                        bit16_o <= data_w[sensor_pkg::SENSOR_16BIT_BIT];
                    sensor_pkg::SEL_SYNC_MULT:
                        sync_mult_o <= data_w[sensor_pkg::SYNC_MULT_W-1:0];
                    sensor_pkg::SEL_GAMMA_PORT:
                        if (data_w[sensor_pkg::GAMMA_ADDR_FLAG_BIT]) begin
                            gamma_ptr <= data_w[sensor_pkg::GAMMA_IDX_W-1:0];
                        end else begin
                            gamma_we  <= 1'b1;
                            gamma_ptr <= gamma_ptr + 1'b1;    // wraps at 64
                        end
                    default: ;
                endcase
            end
        end
    end

    // entry payload, qualified by gamma_we
    always_ff @(posedge mclk) begin
        if (wr_en && (reg_sel == sensor_pkg::SEL_GAMMA_PORT) &&
            !data_w[sensor_pkg::GAMMA_ADDR_FLAG_BIT]) begin
            gamma_idx <= gamma_ptr;
            gamma_val <= data_w[sensor_pkg::GAMMA_OUT_W-1:0];
        end
    end

    assign gamma_wr_o = '{we: gamma_we, idx: gamma_idx, value: gamma_val};

endmodule

//--- rtl/sens_sync.sv
//~~~~~~~~~~~~~~~~~~
// first sof after reset always passes
// new mult is loaded only on a kept frame
//~~~~~~~~~~~~~~~~~~
module sens_sync (
    input  logic                               mclk,
    input  logic                               rst,
    input  logic                               sof_i,        // raw start of frame
    input  logic [sensor_pkg::SYNC_MULT_W-1:0] sync_mult_i,  // frames to skip
    output logic                               sof_o         // decimated, one cycle late
);

    logic [sensor_pkg::SYNC_MULT_W-1:0] skip_cnt;  // frames left to drop
    logic                               keep;

    // pass when nothing left to skip
    assign keep = sof_i && (skip_cnt == '0);

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            skip_cnt <= '0;                        // so the first frame is kept
        end else if (keep) begin
            skip_cnt <= sync_mult_i;               // reload on kept frame
        end else if (sof_i) begin
            skip_cnt <= skip_cnt - 1'b1;           // dropped frame
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            sof_o <= 1'b0;
        end else begin
            sof_o <= keep;                         // t+1
        end
    end

endmodule

//--- rtl/sens_gamma.sv
//~~~~~~~~~~~~~~~~~~
// table contents undefined until loaded
// lookup result two cycles after its pixel
//~~~~~~~~~~~~~~~~~~
module sens_gamma (
    input  logic                  mclk,
    input  logic                  rst,
    input  sensor_pkg::gamma_wr_t wr_i,   // from command block
    input  sensor_pkg::pix_in_t   pix_i,  // raw pixel with synced sof
    output sensor_pkg::pix8_t     pix_o   // gamma-mapped pixel
);

    logic [sensor_pkg::GAMMA_OUT_W-1:0] lut_mem [sensor_pkg::GAMMA_ENTRIES];
    logic [sensor_pkg::GAMMA_IDX_W-1:0] idx_r;     // stage 1 index
    logic                               hact_s1;
    logic                               sof_s1;
    logic                               eof_s1;
    logic [sensor_pkg::GAMMA_OUT_W-1:0] pxd_s2;    // stage 2 lookup
    logic                               hact_s2;
    logic                               sof_s2;
    logic                               eof_s2;

    // write port
    always_ff @(posedge mclk) begin
        if (wr_i.we) begin
            lut_mem[wr_i.idx] <= wr_i.value;
        end
    end

    // stage 1: top bits of the pixel pick the entry
    always_ff @(posedge mclk) begin
        idx_r <= pix_i.pxd[sensor_pkg::PXD_W-1 -: sensor_pkg::GAMMA_IDX_W];
    end

    // stage 2: registered read
    always_ff @(posedge mclk) begin
        pxd_s2 <= lut_mem[idx_r];
    end

    // strobes follow the data
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            hact_s1 <= 1'b0;
            sof_s1  <= 1'b0;
            eof_s1  <= 1'b0;
            hact_s2 <= 1'b0;
            sof_s2  <= 1'b0;
            eof_s2  <= 1'b0;
        end else begin
            hact_s1 <= pix_i.hact;
            sof_s1  <= pix_i.sof;
            eof_s1  <= pix_i.eof;
            hact_s2 <= hact_s1;
            sof_s2  <= sof_s1;
            eof_s2  <= eof_s1;
        end
    end

    assign pix_o = '{pxd: pxd_s2, hact: hact_s2, sof: sof_s2, eof: eof_s2};

endmodule

//--- rtl/pixel_packer.sv
//~~~~~~~~~~~~~~~~~~
// line lengths must be even in 8-bit mode
// no back-pressure, words leave at input rate
//~~~~~~~~~~~~~~~~~~
module pixel_packer (
    input  logic                          mclk,
    input  logic                          rst,
    input  logic                          bit16_i,        // 1 = 16-bit bypass
    input  sensor_pkg::pix_in_t           raw_i,          // bypass path
    input  sensor_pkg::pix8_t             gamma_i,        // 8-bit path, 2 cycles behind raw
    output logic [sensor_pkg::DOUT_W-1:0] dout_o,
    output logic                          dout_valid_o,
    output logic                          last_in_line_o, // with the last word of a line
    output logic                          sof_o,
    output logic                          eof_o
);

    logic                               odd_ph;     // second byte of pair next
    logic [sensor_pkg::GAMMA_OUT_W-1:0] held_byte;  // earlier pixel of the pair
    logic                               pair_done;
    logic                               dav_w;
    logic [sensor_pkg::DOUT_W-1:0]      dout_w;
    logic                               hact_sel;   // hact of the active path

    assign pair_done = gamma_i.hact && odd_ph;
    assign dav_w     = bit16_i ? raw_i.hact : pair_done;
    assign dout_w    = bit16_i ? {raw_i.pxd, 4'b0000}          // msb-aligned
                               : {gamma_i.pxd, held_byte};     // earlier pixel low
    assign hact_sel  = bit16_i ? raw_i.hact : gamma_i.hact;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            odd_ph <= 1'b0;
        end else begin
            odd_ph <= gamma_i.hact && !odd_ph;   // realigns every line
        end
    end

    always_ff @(posedge mclk) begin
        if (gamma_i.hact && !odd_ph) begin
            held_byte <= gamma_i.pxd;
        end
        if (dav_w) begin
            dout_o <= dout_w;
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            dout_valid_o <= 1'b0;
            sof_o        <= 1'b0;
            eof_o        <= 1'b0;
        end else begin
            dout_valid_o <= dav_w;
            sof_o        <= bit16_i ? raw_i.sof : gamma_i.sof;
            eof_o        <= bit16_i ? raw_i.eof : gamma_i.eof;
        end
    end

    // the word register is the extra stage, so hact has already dropped
    // here when this word carried the line's last pixel
    assign last_in_line_o = dout_valid_o && !hact_sel;

endmodule

//--- rtl/sensor_channel.sv
//~~~~~~~~~~~~~~~~~~
// pixels arrive already on mclk
// commands to other channels are ignored
//~~~~~~~~~~~~~~~~~~
module sensor_channel (
    input  logic                          mclk,
    input  logic                          rst,
    input  logic [7:0]                    cmd_ad_i,       // byte-serial command
    input  logic                          cmd_stb_i,
    input  sensor_pkg::pix_in_t           pix_i,
    output logic [sensor_pkg::DOUT_W-1:0] dout_o,
    output logic                          dout_valid_o,
    output logic                          last_in_line_o,
    output logic                          sof_o,
    output logic                          eof_o,
    output logic                          sof_mclk_o      // decimated sof
);

    logic [7:0]                         cmd_ad_r;
    logic                               cmd_stb_r;
    logic                               bit16;
    logic [sensor_pkg::SYNC_MULT_W-1:0] sync_mult;
    sensor_pkg::gamma_wr_t              gamma_wr;
    logic                               sof_sync;
    sensor_pkg::pix_in_t                gamma_in;  // stream with decimated sof
    sensor_pkg::pix8_t                  gamma_out;

    // command bus input register
    always_ff @(posedge mclk) begin
        cmd_ad_r <= cmd_ad_i;
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cmd_stb_r <= 1'b0;
        end else begin
            cmd_stb_r <= cmd_stb_i;
        end
    end

    sensor_cmd_regs cmd_regs_i (
        .mclk        (mclk),
        .rst         (rst),
        .cmd_ad_i    (cmd_ad_r),
        .cmd_stb_i   (cmd_stb_r),
        .bit16_o     (bit16),
        .sync_mult_o (sync_mult),
        .gamma_wr_o  (gamma_wr)
    );

    sens_sync sync_i (
        .mclk        (mclk),
        .rst         (rst),
        .sof_i       (pix_i.sof),
        .sync_mult_i (sync_mult),
        .sof_o       (sof_sync)
    );

    assign gamma_in = '{pxd: pix_i.pxd, hact: pix_i.hact, sof: sof_sync, eof: pix_i.eof};

    sens_gamma gamma_i (
        .mclk  (mclk),
        .rst   (rst),
        .wr_i  (gamma_wr),
        .pix_i (gamma_in),
        .pix_o (gamma_out)
    );

    pixel_packer packer_i (
        .mclk           (mclk),
        .rst            (rst),
        .bit16_i        (bit16),
        .raw_i          (gamma_in),
        .gamma_i        (gamma_out),
        .dout_o         (dout_o),
        .dout_valid_o   (dout_valid_o),
        .last_in_line_o (last_in_line_o),
        .sof_o          (sof_o),
        .eof_o          (eof_o)
    );

    assign sof_mclk_o = sof_sync;

endmodule

//--- tb/sensor_channel_chk.sv
//~~~~~~~~~~~~~~~~~~
// bound into sensor_channel
// mode taken from the internal bit16 register
//~~~~~~~~~~~~~~~~~~
module sensor_channel_chk (
    input logic mclk,
    input logic rst,
    input logic bit16_i,          // internal mode
    input logic dout_valid_i,
    input logic last_in_line_i,
    input logic sof_i,
    input logic eof_i,
    input logic sof_mclk_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt;                 // assertion failures so far

    initial fail_cnt = 0;

    sof_eof_apart: assert property (@(posedge mclk) disable iff (rst)
        !(sof_i && eof_i))
        else begin
            $error("sof_o and eof_o high in the same cycle");
            fail_cnt++;
        end

    // 8-bit mode packs pairs, so at most every other cycle
    valid_gap_8bit: assert property (@(posedge mclk) disable iff (rst)
        (dout_valid_i && !bit16_i) |=> !(dout_valid_i && !bit16_i))
        else begin
            $error("dout_valid_o high two cycles running in 8-bit mode");
            fail_cnt++;
        end

    // a word that does not close its line is followed by the rest of it
    line_end_marked: assert property (@(posedge mclk) disable iff (rst)
        (dout_valid_i && !last_in_line_i) |-> ##[1:2] dout_valid_i)
        else begin
            $error("line ended on a word without last_in_line_o");
            fail_cnt++;
        end

    flags_low_in_reset: assert property (@(posedge mclk)
        rst |-> !(dout_valid_i || last_in_line_i || sof_i || eof_i || sof_mclk_i))
        else begin
            $error("output flag high during reset");
            fail_cnt++;
        end

endmodule

bind sensor_channel sensor_channel_chk chk_i (
    .mclk           (mclk),
    .rst            (rst),
    .bit16_i        (bit16),
    .dout_valid_i   (dout_valid_o),
    .last_in_line_i (last_in_line_o),
    .sof_i          (sof_o),
    .eof_i          (eof_o),
    .sof_mclk_i     (sof_mclk_o)
);

//--- tb/tb_sensor_channel.sv
//~~~~~~~~~~~~~~~~~~
// table-driven testbench, words checked against a queue
// frames are separated by idle gaps, lines by 4 idle cycles
//~~~~~~~~~~~~~~~~~~
module tb_sensor_channel;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NROWS     = 7;
    localparam int DRAIN_TMO = 64;      // cycles allowed for a frame to drain
    localparam logic [15:0] MODE_ADDR  = sensor_pkg::SENSOR_BASE_ADDR
                                         + sensor_pkg::SENSOR_CTRL_RADDR;
    localparam logic [15:0] MULT_ADDR  = sensor_pkg::SENSOR_BASE_ADDR
                                         + sensor_pkg::SENS_SYNC_MULT_RADDR;
    localparam logic [15:0] GAMMA_ADDR = sensor_pkg::SENSOR_BASE_ADDR
                                         + sensor_pkg::SENS_GAMMA_ADDR_DATA_RADDR;
    localparam logic [15:0] OTHER_BASE = 16'h0500;   // neighbour channel

    typedef struct packed {
        logic       bit16;      // 1 = 16-bit bypass
        logic [7:0] mult;       // frame decimation
        logic [3:0] frames;
        logic [7:0] line_len;   // even
        logic [3:0] lines;
        logic [1:0] gamma_op;   // 0 keep, 1 full load, 2 load from 32 up
        logic       foreign;    // also send commands to another channel
    } row_t;

    typedef struct packed {
        logic [15:0] word;
        logic        last;      // last word of a line
    } exp_t;

    logic                mclk;
    logic                rst;
    logic [7:0]          cmd_ad_i;
    logic                cmd_stb_i;
    sensor_pkg::pix_in_t pix_i;
    logic [15:0]         dout_o;
    logic                dout_valid_o;
    logic                last_in_line_o;
    logic                sof_o;
    logic                eof_o;
    logic                sof_mclk_o;

    row_t        rows [NROWS];
    exp_t        exp_q [$];
    exp_t        mon_e;
    logic [7:0]  gamma_model [64];
    logic        model_bit16;
    logic [7:0]  model_mult;
    logic [7:0]  skip_model;    // frames still to drop
    logic [31:0] rnd;
    logic        aborted;
    int          errors;
    int          checks;
    int          sof_cnt;
    int          mclk_cnt;
    int          eof_cnt;
    int          lil_cnt;

    sensor_channel uut (
        .mclk           (mclk),
        .rst            (rst),
        .cmd_ad_i       (cmd_ad_i),
        .cmd_stb_i      (cmd_stb_i),
        .pix_i          (pix_i),
        .dout_o         (dout_o),
        .dout_valid_o   (dout_valid_o),
        .last_in_line_o (last_in_line_o),
        .sof_o          (sof_o),
        .eof_o          (eof_o),
        .sof_mclk_o     (sof_mclk_o)
    );

    initial begin
        mclk = 1'b0;
        forever #20 mclk = ~mclk;        // 40 ns period
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fill_table();
        //          bit16 mult   frm   len    lines gamma  foreign
        rows[0] = '{1'b1, 8'd0, 4'd2, 8'd8,  4'd3, 2'd0, 1'b0};
        rows[1] = '{1'b0, 8'd0, 4'd2, 8'd10, 4'd3, 2'd1, 1'b0};   // full table load
        rows[2] = '{1'b0, 8'd0, 4'd2, 8'd6,  4'd2, 2'd2, 1'b0};   // upper half only
        rows[3] = '{1'b0, 8'd2, 4'd7, 8'd4,  4'd2, 2'd0, 1'b0};   // keep 0, 3, 6
        rows[4] = '{1'b1, 8'd0, 4'd3, 8'd6,  4'd2, 2'd0, 1'b0};
        rows[5] = '{1'b0, 8'd0, 4'd2, 8'd8,  4'd2, 2'd0, 1'b1};
        rows[6] = '{1'b1, 8'd1, 4'd4, 8'd4,  4'd2, 2'd0, 1'b1};
    endtask

    task automatic drive_pix(input logic hact, input logic sof, input logic eof,
                             input logic [11:0] pxd);
        @(posedge mclk);
        pix_i <= '{pxd: pxd, hact: hact, sof: sof, eof: eof};
    endtask

    task automatic idle(input int n);
        repeat (n) drive_pix(1'b0, 1'b0, 1'b0, 12'd0);
    endtask

    // AL, AH, then data bytes low first
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] seq;
        seq = {data, addr};
        for (int i = 0; i < sensor_pkg::CMD_NUM_BYTES; i++) begin
            @(posedge mclk);
            cmd_stb_i <= (i == 0);
            cmd_ad_i  <= seq[8*i +: 8];
        end
    endtask

    task automatic load_gamma(input int first);
        logic [7:0] v;
        send_cmd(GAMMA_ADDR, (32'd1 << sensor_pkg::GAMMA_ADDR_FLAG_BIT) | first);
        for (int i = first; i < 64; i++) begin
            rnd = next_rand(rnd);
            v = rnd[7:0];
            gamma_model[i] = v;
            send_cmd(GAMMA_ADDR, {24'd0, v});
        end
    endtask

    // writes aimed at the neighbour, none of them may land here
    task automatic send_foreign(input logic bit16);
        send_cmd(OTHER_BASE + sensor_pkg::SENSOR_CTRL_RADDR,
                 32'(!bit16) << sensor_pkg::SENSOR_16BIT_BIT);
        send_cmd(OTHER_BASE + sensor_pkg::SENS_SYNC_MULT_RADDR, 32'd3);
        send_cmd(OTHER_BASE + sensor_pkg::SENS_GAMMA_ADDR_DATA_RADDR,
                 32'd1 << sensor_pkg::GAMMA_ADDR_FLAG_BIT);
        send_cmd(OTHER_BASE + sensor_pkg::SENS_GAMMA_ADDR_DATA_RADDR, 32'h0000_00a5);
    endtask

    task automatic check_count(input string name, input int exp_v, input int got_v);
        checks++;
        assert (got_v == exp_v) else begin
            $display("FAIL t=%0t %s pulses exp=%0d got=%0d", $time, name, exp_v, got_v);
            errors++;
        end
    endtask

    task automatic run_frame(input row_t r);
        logic        keep;
        logic [11:0] px;
        logic [11:0] prev_px;
        int          tmo;
        keep = (skip_model == 8'd0);
        if (keep)
            skip_model = model_mult;     // kept frame reloads the count
        else
            skip_model = skip_model - 8'd1;
        prev_px  = '0;
        sof_cnt  = 0;
        mclk_cnt = 0;
        eof_cnt  = 0;
        lil_cnt  = 0;
        drive_pix(1'b0, 1'b1, 1'b0, 12'd0);
        idle(2);
        for (int l = 0; l < r.lines; l++) begin
            for (int p = 0; p < r.line_len; p++) begin
                rnd = next_rand(rnd);
                px = rnd[11:0];
                drive_pix(1'b1, 1'b0, 1'b0, px);
                if (model_bit16)
                    exp_q.push_back(exp_t'{word: {px, 4'h0}, last: (p == r.line_len - 1)});
                else if (p % 2 == 1)         // pair complete, earlier pixel low
                    exp_q.push_back(exp_t'{word: {gamma_model[px[11:6]],
                                                  gamma_model[prev_px[11:6]]},
                                           last: (p == r.line_len - 1)});
                prev_px = px;
            end
            idle(4);
        end
        drive_pix(1'b0, 1'b0, 1'b1, 12'd0);
        tmo = 0;
        while ((exp_q.size() != 0 || eof_cnt == 0) && tmo < DRAIN_TMO) begin
            idle(1);
            tmo++;
        end
        if (tmo >= DRAIN_TMO) begin
            $display("timeout at %0t: frame did not drain, %0d words still missing",
                     $time, exp_q.size());
            aborted = 1'b1;
        end
        idle(4);
        check_count("sof_o", keep, sof_cnt);
        check_count("sof_mclk_o", keep, mclk_cnt);
        check_count("eof_o", 1, eof_cnt);
        check_count("last_in_line_o", r.lines, lil_cnt);
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   errs_before;
        r = rows[idx];
        errs_before = errors;
        send_cmd(MODE_ADDR, 32'(r.bit16) << sensor_pkg::SENSOR_16BIT_BIT);
        model_bit16 = r.bit16;
        send_cmd(MULT_ADDR, {24'd0, r.mult});
        model_mult = r.mult;
        if (r.gamma_op == 2'd1)
            load_gamma(0);
        else if (r.gamma_op == 2'd2)
            load_gamma(32);
        if (r.foreign)
            send_foreign(r.bit16);
        idle(10);                               // last write lands 7 cycles after strobe
        for (int f = 0; f < r.frames && !aborted; f++) begin
            run_frame(r);
        end
        $display("row %0d: %0s mode, mult %0d, %0d frames of %0d lines x %0d, %0d errors",
                 idx, r.bit16 ? "16-bit" : "8-bit", r.mult, r.frames, r.lines, r.line_len,
                 errors - errs_before);
    endtask

    // outputs settle well before the falling edge
    always @(negedge mclk) begin
        if (!rst) begin
            if (sof_o) sof_cnt++;
            if (sof_mclk_o) mclk_cnt++;
            if (eof_o) eof_cnt++;
            if (last_in_line_o) lil_cnt++;
            if (dout_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected word %h at %0t while nothing was expected",
                             dout_o, $time);
                    errors++;
                end else begin
                    mon_e = exp_q.pop_front();
                    checks += 2;
                    assert (dout_o === mon_e.word) else begin
                        $display("FAIL t=%0t dout_o exp=%h got=%h", $time, mon_e.word, dout_o);
                        errors++;
                    end
                    assert (last_in_line_o === mon_e.last) else begin
                        $display("FAIL t=%0t last_in_line_o exp=%b got=%b",
                                 $time, mon_e.last, last_in_line_o);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        rst         = 1'b1;
        cmd_ad_i    = '0;
        cmd_stb_i   = 1'b0;
        pix_i       = '0;
        errors      = 0;
        checks      = 0;
        sof_cnt     = 0;
        mclk_cnt    = 0;
        eof_cnt     = 0;
        lil_cnt     = 0;
        aborted     = 1'b0;
        rnd         = 32'd77;
        model_bit16 = 1'b0;
        model_mult  = '0;
        skip_model  = '0;        // first frame after reset is kept
        fill_table();
        repeat (8) @(posedge mclk);
        rst <= 1'b0;
        idle(4);
        for (int r = 0; r < NROWS && !aborted; r++) begin
            run_row(r);
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, uut.chk_i.fail_cnt);
        if (errors == 0 && !aborted && uut.chk_i.fail_cnt == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- files.f
rtl/sensor_pkg.sv
rtl/sensor_cmd_regs.sv
rtl/sens_sync.sv
rtl/sens_gamma.sv
rtl/pixel_packer.sv
rtl/sensor_channel.sv
tb/sensor_channel_chk.sv
tb/tb_sensor_channel.sv

//--- Bender.yml
package:
  name: sensor_channel

sources:
  # design, package first
  - rtl/sensor_pkg.sv
  - rtl/sensor_cmd_regs.sv
  - rtl/sens_sync.sv
  - rtl/sens_gamma.sv
  - rtl/pixel_packer.sv
  - rtl/sensor_channel.sv

  # testbench and bound checker
  - target: test
    files:
      - tb/sensor_channel_chk.sv
      - tb/tb_sensor_channel.sv

# top modules: tb_sensor_channel (simulation), sensor_channel (design)
